//--- rtl/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [4:0]  alu_op_t;

    typedef enum logic [2:0] {IF, ID, EX, MEM, STP} state_t;
    typedef enum logic [1:0] {OTHER, STORE, LOAD, LINK} instr_class_t;

    localparam word_t reset_vector = 32'hBFC0_0000;

    localparam alu_op_t ALU_ADDU   = 5'd0;
    localparam alu_op_t ALU_SUBU   = 5'd1;
    localparam alu_op_t ALU_AND    = 5'd2;
    localparam alu_op_t ALU_OR     = 5'd3;
    localparam alu_op_t ALU_XOR    = 5'd4;
    localparam alu_op_t ALU_SLT    = 5'd5;
    localparam alu_op_t ALU_SLTU   = 5'd6;
    localparam alu_op_t ALU_SLL    = 5'd7;
    localparam alu_op_t ALU_SRL    = 5'd8;
    localparam alu_op_t ALU_MULTU  = 5'd9;
    localparam alu_op_t ALU_PASS_A = 5'd10;
    localparam alu_op_t ALU_LUI    = 5'd11;
    localparam alu_op_t ALU_EQ     = 5'd12;
    localparam alu_op_t ALU_NE     = 5'd13;
    localparam alu_op_t ALU_GEZ    = 5'd14;
    localparam alu_op_t ALU_LTZ    = 5'd15;

    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0A;
    localparam opcode_t OP_ANDI    = 6'h0C;
    localparam opcode_t OP_ORI     = 6'h0D;
    localparam opcode_t OP_LUI     = 6'h0F;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2B;

    localparam opcode_t FN_SLL   = 6'h00;
    localparam opcode_t FN_SRL   = 6'h02;
    localparam opcode_t FN_JR    = 6'h08;
    localparam opcode_t FN_MFHI  = 6'h10;
    localparam opcode_t FN_MTHI  = 6'h11;
    localparam opcode_t FN_MFLO  = 6'h12;
    localparam opcode_t FN_MTLO  = 6'h13;
    localparam opcode_t FN_MULTU = 6'h19;
    localparam opcode_t FN_ADDU  = 6'h21;
    localparam opcode_t FN_SUBU  = 6'h23;
    localparam opcode_t FN_AND   = 6'h24;
    localparam opcode_t FN_OR    = 6'h25;
    localparam opcode_t FN_XOR   = 6'h26;
    localparam opcode_t FN_SLT   = 6'h2A;
    localparam opcode_t FN_SLTU  = 6'h2B;

    // Datapath select encodings
    localparam logic [1:0] PC_SRC_INC    = 2'd0;
    localparam logic [1:0] PC_SRC_BRANCH = 2'd1;
    localparam logic [1:0] PC_SRC_JUMP   = 2'd2;
    localparam logic [1:0] PC_SRC_REG    = 2'd3;

    localparam logic [1:0] SRC_A_PC  = 2'd0;
    localparam logic [1:0] SRC_A_REG = 2'd1;
    localparam logic [1:0] SRC_A_B   = 2'd2;

    localparam logic [1:0] SRC_B_REG    = 2'd0;
    localparam logic [1:0] SRC_B_IMM    = 2'd1;
    localparam logic [1:0] SRC_B_BRANCH = 2'd2;

    localparam logic [1:0] DST_RT = 2'd0;
    localparam logic [1:0] DST_RD = 2'd1;
    localparam logic [1:0] DST_RA = 2'd2;

    localparam logic [2:0] WB_ALU  = 3'd0;
    localparam logic [2:0] WB_MEM  = 3'd1;
    localparam logic [2:0] WB_HI   = 3'd2;
    localparam logic [2:0] WB_LO   = 3'd3;
    localparam logic [2:0] WB_LINK = 3'd4;

endpackage

//--- rtl/mips_cpu_control.sv
`timescale 1ns/1ps

module mips_cpu_control (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::opcode_t  op,
    input  mips_pkg::opcode_t  func,
    input  mips_pkg::reg_idx_t rt,
    input  logic               waitrequest,
    input  logic               pc_zero,
    output logic               active,
    output logic               mem_read,
    output logic               mem_write,
    output logic               iord,
    output logic               ir_write,
    output logic               reg_write,
    output logic [1:0]         reg_dst,
    output logic [2:0]         reg_data_sel,
    output logic [1:0]         alu_src_a,
    output logic [1:0]         alu_src_b,
    output mips_pkg::alu_op_t  alu_op,
    output logic [1:0]         pc_src,
    output logic               pc_write,
    output logic               pc_write_cond,
    output logic               hi_en,
    output logic               lo_en,
    output logic               hi_lo_sel,
    output logic               sign_extend
);
    import mips_pkg::*;

    state_t       state;
    instr_class_t cls;

    always_comb begin
        cls = OTHER;
        if (op == OP_LW) begin
            cls = LOAD;
        end else if (op == OP_SW) begin
            cls = STORE;
        end else if (op == OP_JAL) begin
            cls = LINK;
        end else if (op == OP_SPECIAL && (func == FN_MFHI || func == FN_MFLO)) begin
            cls = LINK; // Written back from HI/LO in MEM
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IF;
        end else begin
            case (state)
                IF: begin
                    if (pc_zero) begin
                        state <= STP;
                    end else if (!waitrequest) begin
                        state <= ID;
                    end
                end
                ID: state <= EX;
                EX: begin
                    if ((cls == LOAD || cls == STORE) && waitrequest) begin
                        state <= EX; // Bus transfer still pending
                    end else if (cls == LOAD || cls == LINK) begin
                        state <= MEM;
                    end else begin
                        state <= IF;
                    end
                end
                MEM: state <= IF;
                default: state <= STP;
            endcase
        end
    end

    assign active = (state != STP);

    always_comb begin
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        iord          = 1'b0;
        ir_write      = 1'b0;
        reg_write     = 1'b0;
        reg_dst       = DST_RT;
        reg_data_sel  = WB_ALU;
        alu_src_a     = SRC_A_REG;
        alu_src_b     = SRC_B_REG;
        alu_op        = ALU_ADDU;
        pc_src        = PC_SRC_INC;
        pc_write      = 1'b0;
        pc_write_cond = 1'b0;
        hi_en         = 1'b0;
        lo_en         = 1'b0;
        hi_lo_sel     = 1'b0;
        sign_extend   = 1'b1;
        case (state)
            IF: begin
                if (!pc_zero) begin
                    mem_read = 1'b1;
                    ir_write = !waitrequest;
                    pc_write = !waitrequest;
                end
            end
            ID: begin
                alu_src_a = SRC_A_PC; // Branch target into ALU result register
                alu_src_b = SRC_B_BRANCH;
            end
            EX: begin
                case (op)
                    OP_SPECIAL: begin
                        reg_dst   = DST_RD;
                        reg_write = 1'b1;
                        case (func)
                            FN_ADDU: alu_op = ALU_ADDU;
                            FN_SUBU: alu_op = ALU_SUBU;
                            FN_AND:  alu_op = ALU_AND;
                            FN_OR:   alu_op = ALU_OR;
                            FN_XOR:  alu_op = ALU_XOR;
                            FN_SLT:  alu_op = ALU_SLT;
                            FN_SLTU: alu_op = ALU_SLTU;
                            FN_SLL, FN_SRL: begin
                                alu_op    = (func == FN_SLL) ? ALU_SLL : ALU_SRL;
                                alu_src_a = SRC_A_B;
                                alu_src_b = SRC_B_IMM; // Carries shamt
                            end
                            FN_MULTU: begin
                                alu_op    = ALU_MULTU;
                                reg_write = 1'b0;
                                hi_en     = 1'b1;
                                lo_en     = 1'b1;
                            end
                            FN_MTHI, FN_MTLO: begin
                                alu_op    = ALU_PASS_A;
                                reg_write = 1'b0;
                                hi_en     = (func == FN_MTHI);
                                lo_en     = (func == FN_MTLO);
                                hi_lo_sel = 1'b1;
                            end
                            FN_JR: begin
                                alu_op        = ALU_PASS_A;
                                reg_write     = 1'b0;
                                pc_src        = PC_SRC_REG;
                                pc_write      = 1'b1;
                                pc_write_cond = 1'b1;
                            end
                            default: reg_write = 1'b0;
                        endcase
                    end
                    OP_BEQ, OP_BNE, OP_REGIMM: begin
                        if (op == OP_BEQ) begin
                            alu_op = ALU_EQ;
                        end else if (op == OP_BNE) begin
                            alu_op = ALU_NE;
                        end else begin
                            alu_op = rt[0] ? ALU_GEZ : ALU_LTZ;
                        end
                        pc_src        = PC_SRC_BRANCH;
                        pc_write      = 1'b1;
                        pc_write_cond = 1'b1;
                    end
                    OP_J, OP_JAL: begin
                        alu_op        = ALU_PASS_A;
                        alu_src_a     = SRC_A_PC; // Link address kept for MEM
                        pc_src        = PC_SRC_JUMP;
                        pc_write      = 1'b1;
                        pc_write_cond = 1'b1;
                    end
                    OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI: begin
                        alu_src_b = SRC_B_IMM;
                        reg_write = 1'b1;
                        case (op)
                            OP_SLTI: alu_op = ALU_SLT;
                            OP_ANDI: alu_op = ALU_AND;
                            OP_ORI:  alu_op = ALU_OR;
                            OP_LUI:  alu_op = ALU_LUI;
                            default: alu_op = ALU_ADDU;
                        endcase
                        sign_extend = !(op == OP_ANDI || op == OP_ORI);
                    end
                    OP_LW, OP_SW: begin
                        alu_src_b = SRC_B_IMM;
                        iord      = 1'b1;
                        mem_read  = (op == OP_LW);
                        mem_write = (op == OP_SW);
                    end
                    default: ;
                endcase
            end
            MEM: begin
                reg_write = 1'b1;
                if (cls == LOAD) begin
                    reg_data_sel = WB_MEM;
                end else if (op == OP_JAL) begin
                    reg_dst      = DST_RA;
                    reg_data_sel = WB_LINK;
                end else begin
                    reg_dst      = DST_RD;
                    reg_data_sel = (func == FN_MFHI) ? WB_HI : WB_LO;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/mips_cpu_pc.sv
`timescale 1ns/1ps

module mips_cpu_pc (
    input  logic            clk,
    input  logic            reset,
    input  logic            pc_write,
    input  logic            pc_write_cond,
    input  logic            cond,
    input  logic [1:0]      pc_src,
    input  mips_pkg::word_t alu_result,
    input  mips_pkg::word_t jump_target,
    input  mips_pkg::word_t reg_target,
    output mips_pkg::word_t pc,
    output logic            pc_zero
);
    import mips_pkg::*;

    word_t pc_next;

    always_comb begin
        case (pc_src)
            PC_SRC_BRANCH: pc_next = reg_target; // Target saved during ID
            PC_SRC_JUMP:   pc_next = jump_target;
            PC_SRC_REG:    pc_next = alu_result; // rs passed through ALU
            default:       pc_next = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (pc_write && (!pc_write_cond || cond)) begin
            pc <= pc_next;
        end
    end

    assign pc_zero = (pc == '0);

endmodule

//--- rtl/mips_cpu_alu.sv
`timescale 1ns/1ps

module mips_cpu_alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    input  mips_pkg::alu_op_t alu_op,
    output mips_pkg::word_t   result,
    output mips_pkg::word_t   hi,
    output mips_pkg::word_t   lo,
    output logic              cond
);
    import mips_pkg::*;

    logic [63:0] product;

    assign product = 64'(a) * 64'(b); // Unsigned only
    assign hi      = product[63:32];
    assign lo      = product[31:0];

    always_comb begin
        case (alu_op)
            ALU_ADDU:   result = a + b;
            ALU_SUBU:   result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {31'd0, a < b};
            ALU_SLL:    result = a << shamt;
            ALU_SRL:    result = a >> shamt;
            ALU_MULTU:  result = product[31:0];
            ALU_PASS_A: result = a;
            ALU_LUI:    result = {b[15:0], 16'h0000};
            default:    result = '0;
        endcase
    end

    // Branch and jump decision
    always_comb begin
        case (alu_op)
            ALU_EQ:     cond = (a == b);
            ALU_NE:     cond = (a != b);
            ALU_GEZ:    cond = !a[31];
            ALU_LTZ:    cond = a[31];
            ALU_PASS_A: cond = 1'b1;
            default:    cond = 1'b0;
        endcase
    end

endmodule

//--- rtl/mips_cpu_regfile.sv
`timescale 1ns/1ps

module mips_cpu_regfile (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::word_t    wr_data,
    input  logic               reg_write,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    register_v0
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && wr_idx != '0) begin
            regs[wr_idx] <= wr_data; // r0 stays zero
        end
    end

    assign rs_data     = regs[rs_idx];
    assign rt_data     = regs[rt_idx];
    assign register_v0 = regs[2];

endmodule

//--- rtl/mips_cpu_datapath.sv
`timescale 1ns/1ps

module mips_cpu_datapath (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_read,
    input  logic               iord,
    input  logic               ir_write,
    input  logic [1:0]         reg_dst,
    input  logic [2:0]         reg_data_sel,
    input  logic [1:0]         alu_src_a,
    input  logic [1:0]         alu_src_b,
    input  logic               hi_en,
    input  logic               lo_en,
    input  logic               hi_lo_sel,
    input  logic               sign_extend,
    input  mips_pkg::word_t    readdata,
    input  mips_pkg::word_t    pc,
    input  mips_pkg::word_t    alu_result,
    input  mips_pkg::word_t    alu_hi,
    input  mips_pkg::word_t    alu_lo,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    address,
    output mips_pkg::word_t    writedata,
    output mips_pkg::opcode_t  op,
    output mips_pkg::opcode_t  func,
    output mips_pkg::reg_idx_t rt,
    output mips_pkg::word_t    alu_a,
    output mips_pkg::word_t    alu_b,
    output mips_pkg::reg_idx_t wr_idx,
    output mips_pkg::word_t    wr_data,
    output mips_pkg::reg_idx_t rs_idx,
    output mips_pkg::word_t    jump_target,
    output mips_pkg::word_t    reg_target
);
    import mips_pkg::*;

    word_t ir;
    word_t a_reg, b_reg;
    word_t alu_out;
    word_t hi_reg, lo_reg;
    word_t mdr;
    word_t imm_ext;

    assign op          = ir[31:26];
    assign rs_idx      = ir[25:21];
    assign rt          = ir[20:16];
    assign func        = ir[5:0];
    assign imm_ext     = sign_extend ? {{16{ir[15]}}, ir[15:0]} : {16'h0000, ir[15:0]};
    assign jump_target = {pc[31:28], ir[25:0], 2'b00};
    assign reg_target  = alu_out;
    assign address     = iord ? alu_result : pc;
    assign writedata   = b_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;
        end else if (ir_write) begin
            ir <= readdata;
        end
    end

    always_ff @(posedge clk) begin
        a_reg   <= rs_data;
        b_reg   <= rt_data;
        alu_out <= alu_result; // Branch target after ID, link address after EX
        if (mem_read && iord) begin
            mdr <= readdata; // Last capture is the completing cycle
        end
        if (hi_en) begin
            hi_reg <= hi_lo_sel ? alu_result : alu_hi;
        end
        if (lo_en) begin
            lo_reg <= hi_lo_sel ? alu_result : alu_lo;
        end
    end

    always_comb begin
        case (alu_src_a)
            SRC_A_PC: alu_a = pc;
            SRC_A_B:  alu_a = b_reg; // Shift operand
            default:  alu_a = a_reg;
        endcase
        case (alu_src_b)
            SRC_B_IMM:    alu_b = imm_ext;
            SRC_B_BRANCH: alu_b = {imm_ext[29:0], 2'b00};
            default:      alu_b = b_reg;
        endcase
        case (reg_dst)
            DST_RD:  wr_idx = ir[15:11];
            DST_RA:  wr_idx = 5'd31;
            default: wr_idx = rt;
        endcase
        case (reg_data_sel)
            WB_MEM:  wr_data = mdr;
            WB_HI:   wr_data = hi_reg;
            WB_LO:   wr_data = lo_reg;
            WB_LINK: wr_data = alu_out;
            default: wr_data = alu_result;
        endcase
    end

endmodule

//--- rtl/mips_cpu.sv
`timescale 1ns/1ps

module mips_cpu (
    input  logic            clk,
    input  logic            reset,
    output logic            active,
    output mips_pkg::word_t register_v0,
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    input  logic            waitrequest,
    output mips_pkg::word_t writedata,
    input  mips_pkg::word_t readdata
);
    import mips_pkg::*;

    logic       iord, ir_write, reg_write;
    logic [1:0] reg_dst, alu_src_a, alu_src_b, pc_src;
    logic [2:0] reg_data_sel;
    alu_op_t    alu_op;
    logic       pc_write, pc_write_cond, cond, pc_zero;
    logic       hi_en, lo_en, hi_lo_sel, sign_extend;
    opcode_t    op, func;
    reg_idx_t   rt, rs_idx, wr_idx;
    word_t      pc, alu_result, alu_hi, alu_lo, alu_a, alu_b;
    word_t      rs_data, rt_data, wr_data, jump_target, reg_target;

    mips_cpu_control i_control (
        .clk, .reset, .op, .func, .rt, .waitrequest, .pc_zero, .active,
        .mem_read(read), .mem_write(write), .iord, .ir_write, .reg_write,
        .reg_dst, .reg_data_sel, .alu_src_a, .alu_src_b, .alu_op,
        .pc_src, .pc_write, .pc_write_cond, .hi_en, .lo_en, .hi_lo_sel, .sign_extend
    );

    mips_cpu_pc i_pc (
        .clk, .reset, .pc_write, .pc_write_cond, .cond, .pc_src,
        .alu_result, .jump_target, .reg_target, .pc, .pc_zero
    );

    mips_cpu_datapath i_datapath (
        .clk, .reset, .mem_read(read), .iord, .ir_write, .reg_dst, .reg_data_sel,
        .alu_src_a, .alu_src_b, .hi_en, .lo_en, .hi_lo_sel, .sign_extend,
        .readdata, .pc, .alu_result, .alu_hi, .alu_lo, .rs_data, .rt_data,
        .address, .writedata, .op, .func, .rt, .alu_a, .alu_b,
        .wr_idx, .wr_data, .rs_idx, .jump_target, .reg_target
    );

    mips_cpu_alu i_alu (
        .a(alu_a),
        .b(alu_b),
        .shamt(alu_b[10:6]), // Shift amount rides in the immediate
        .alu_op,
        .result(alu_result),
        .hi(alu_hi),
        .lo(alu_lo),
        .cond
    );

    mips_cpu_regfile i_regfile (
        .clk, .reset, .rs_idx, .rt_idx(rt), .wr_idx, .wr_data, .reg_write,
        .rs_data, .rt_data, .register_v0
    );

endmodule

//--- test/mips_cpu_tb.sv
`timescale 1ns/1ps

module mips_cpu_tb;
    import mips_pkg::*;

    logic  clk;
    logic  reset;
    logic  waitrequest;
    logic  active;
    logic  write;
    logic  read;
    word_t register_v0;
    word_t address;
    word_t writedata;
    word_t readdata;

    word_t mem [logic [29:0]];        // Word addressed
    word_t expect_mem [logic [29:0]];
    word_t expect_v0;
    integer seed;
    int    errors;
    int    cycles;
    logic  store_held;
    word_t held_addr;
    word_t held_data;

    mips_cpu i_dut (
        .clk,
        .reset,
        .active,
        .register_v0,
        .address,
        .write,
        .read,
        .waitrequest,
        .writedata,
        .readdata
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t read_word(word_t addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return ~addr; // Unwritten words follow their address
    endfunction

    assign readdata = read_word(address); // Valid in the same cycle

    task automatic check_word(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_input();
        int    fd;
        int    n;
        string line;
        byte   kind;
        word_t addr;
        word_t val;
        fd = $fopen("test/mips_cpu_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the input file test/mips_cpu_input.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && $sscanf(line, "%c %h %h", kind, addr, val) == 3) begin
                    case (kind)
                        "P": mem[addr[31:2]] = val;
                        "M": expect_mem[addr[31:2]] = val;
                        "V": expect_v0 = val;
                        default: ; // Comment line
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // Bus model and protocol checks
    always @(posedge clk) begin
        if (!reset) begin
            if (write && !waitrequest) begin
                mem[address[31:2]] = writedata;
            end
            if (read && write) begin
                $display("Read and write were both high at address %h", address);
                errors++;
            end
            if (store_held && !(write && address == held_addr && writedata == held_data)) begin
                $display("A store changed while waitrequest was holding it");
                errors++;
            end
            if (!active && (read || write)) begin
                $display("Bus access at address %h after the core stopped", address);
                errors++;
            end
            store_held <= write && waitrequest;
            held_addr  <= address;
            held_data  <= writedata;
        end
        waitrequest <= ($random(seed) % 3) == 0; // About one cycle in three
    end

    initial begin
        seed        = 34;
        errors      = 0;
        store_held  = 1'b0;
        expect_v0   = '0;
        reset       = 1'b1;
        waitrequest = 1'b0;
        load_input();

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // First cycle out of reset
        @(negedge clk);
        check_word("reset vector address", 32'hBFC0_0000, address);
        check_word("read after reset", 32'd1, {31'd0, read});
        check_word("write after reset", 32'd0, {31'd0, write});

        cycles = 0;
        while (active && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (active) begin
            $display("Timeout: active did not fall within 20000 cycles");
            errors++;
        end else begin
            for (int i = 0; i < 10; i++) begin
                @(posedge clk); // Bus must stay idle
            end
            foreach (expect_mem[a]) begin
                check_word($sformatf("mem[%h]", {a, 2'b00}), expect_mem[a],
                           mem.exists(a) ? mem[a] : 32'd0);
            end
            check_word("register_v0", expect_v0, register_v0);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- test/mips_cpu_input.txt
# kind address value (hex)
# P program or data word, M expected final memory word, V expected register_v0
P BFC00000 3C081234
P BFC00004 35085678
P BFC00008 2409FFFD
P BFC0000C 01095021
P BFC00010 AC0A0100
P BFC00014 01095026
P BFC00018 AC0A0104
P BFC0001C 00085100
P BFC00020 0128582A
P BFC00024 0128602B
P BFC00028 014B5023
P BFC0002C 014C5021
P BFC00030 AC0A0108
P BFC00034 00085202
P BFC00038 312BFF0F
P BFC0003C 014B5024
P BFC00040 292BFFFE
P BFC00044 014B5021
P BFC00048 AC0A010C
P BFC0004C 01090019
P BFC00050 00005010
P BFC00054 AC0A0110
P BFC00058 00005012
P BFC0005C AC0A0114
P BFC00060 01200011
P BFC00064 01000013
P BFC00068 00005810
P BFC0006C 00006012
P BFC00070 016C5023
P BFC00074 AC0A0118
P BFC00078 240A0000
P BFC0007C 11090001
P BFC00080 254A0001
P BFC00084 15090001
P BFC00088 254A0100
P BFC0008C 05210001
P BFC00090 254A0002
P BFC00094 05200001
P BFC00098 254A0200
P BFC0009C 11080001
P BFC000A0 254A0400
P BFC000A4 05000001
P BFC000A8 254A0004
P BFC000AC 05010001
P BFC000B0 254A0800
P BFC000B4 15080001
P BFC000B8 254A0008
P BFC000BC 0BF00031
P BFC000C0 254A1000
P BFC000C4 0FF00035
P BFC000C8 AC0B011C
P BFC000CC AC1F0120
P BFC000D0 00000008
P BFC000D4 8C0B0140
P BFC000D8 014B5021
P BFC000DC AC0A0124
P BFC000E0 25420010
P BFC000E4 03E00008
P 00000140 A5A50001
M 00000100 12345675
M 00000104 EDCBA985
M 00000108 2345677F
M 0000010C 00003405
M 00000110 12345677
M 00000114 C962FC98
M 00000118 EDCBA985
M 0000011C A5A50001
M 00000120 BFC000C8
M 00000124 A5A50010
M 00000140 A5A50001
V 00000000 A5A50020

//--- mips_cpu.f
rtl/mips_pkg.sv
rtl/mips_cpu_control.sv
rtl/mips_cpu_pc.sv
rtl/mips_cpu_alu.sv
rtl/mips_cpu_regfile.sv
rtl/mips_cpu_datapath.sv
rtl/mips_cpu.sv
test/mips_cpu_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --top-module mips_cpu_tb -f mips_cpu.f -o mips_cpu_sim
	./obj_dir/mips_cpu_sim | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
